//--- hdl/csr_file.sv
`timescale 1ns/1ps

module csr_file
    import pipeline_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,

    input  logic [13:0]      csr_raddr_i,
    input  csr_wr_t          csr_wr_i,
    input  trap_entry_t      trap_i,
    input  logic             ertn_i,
    input  logic [INT_W-1:0] int_pending_i,

    output logic [31:0]      csr_rdata_o,
    output csr_view_t        csr_view_o,
    output timer_cfg_t       timer_cfg_o,
    output logic             timer_clr_o
);

    logic [1:0]       crmd_plv_q;
    logic             crmd_ie_q;
    logic [1:0]       prmd_pplv_q;
    logic             prmd_pie_q;
    logic [INT_W-1:0] ecfg_lie_q;
    logic [INT_W-1:0] estat_is_q;
    exc_code_e        estat_ecode_q;
    logic [31:0]      era_q;
    logic [31:0]      badv_q;
    logic [31:0]      eentry_q;
    logic             tcfg_en_q;
    logic             tcfg_periodic_q;
    logic [29:0]      tcfg_init_q;

    logic [31:0]      wdata;
    logic             wr_tcfg;

    assign wdata = csr_wr_i.csr_write_data;
    assign wr_tcfg = csr_wr_hit(csr_wr_i, CSR_TCFG);
    assign timer_clr_o = csr_wr_hit(csr_wr_i, CSR_TICLR) && wdata[0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crmd_plv_q      <= 2'b00;
            crmd_ie_q       <= 1'b0;
            prmd_pplv_q     <= 2'b00;
            prmd_pie_q      <= 1'b0;
            ecfg_lie_q      <= '0;
            estat_ecode_q   <= EXC_INT;
            era_q           <= '0;
            badv_q          <= '0;
            eentry_q        <= '0;
            tcfg_en_q       <= 1'b0;
            tcfg_periodic_q <= 1'b0;
            tcfg_init_q     <= '0;
        end
        else begin
            if (csr_wr_hit(csr_wr_i, CSR_CRMD)) begin
                crmd_plv_q <= wdata[1:0];
                crmd_ie_q  <= wdata[2];
            end
            if (csr_wr_hit(csr_wr_i, CSR_PRMD)) begin
                prmd_pplv_q <= wdata[1:0];
                prmd_pie_q  <= wdata[2];
            end
            if (csr_wr_hit(csr_wr_i, CSR_ECFG)) begin
                ecfg_lie_q <= int_field(wdata);
            end
            if (csr_wr_hit(csr_wr_i, CSR_ERA)) begin
                era_q <= wdata;
            end
            if (csr_wr_hit(csr_wr_i, CSR_BADV)) begin
                badv_q <= wdata;
            end
            if (csr_wr_hit(csr_wr_i, CSR_EENTRY)) begin
                eentry_q <= wdata;
            end
            if (wr_tcfg) begin
                tcfg_en_q       <= wdata[0];
                tcfg_periodic_q <= wdata[1];
                tcfg_init_q     <= wdata[31:2];
            end

            // trap state is written last so it overrides a software write.
            if (trap_i.is_exception) begin
                prmd_pplv_q   <= crmd_plv_q;
                prmd_pie_q    <= crmd_ie_q;
                crmd_plv_q    <= 2'b00;
                crmd_ie_q     <= 1'b0;
                era_q         <= trap_i.exception_pc;
                estat_ecode_q <= trap_i.exception_cause;
                if (trap_i.exception_cause == EXC_ADEF || trap_i.exception_cause == EXC_ALE) begin
                    badv_q <= trap_i.exception_addr;
                end
            end
            else if (ertn_i) begin
                crmd_plv_q <= prmd_pplv_q;
                crmd_ie_q  <= prmd_pie_q;
            end
        end
    end

    // hardware and timer bits follow the sources, the two low bits belong to software.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            estat_is_q <= '0;
        end
        else begin
            estat_is_q[11]   <= int_pending_i[11] && !timer_clr_o;
            estat_is_q[10:2] <= int_pending_i[10:2];
            if (csr_wr_hit(csr_wr_i, CSR_ESTAT)) begin
                estat_is_q[1:0] <= wdata[1:0];
            end
        end
    end

    always_comb begin
        case (csr_raddr_i)
            CSR_CRMD:   csr_rdata_o = {29'b0, crmd_ie_q, crmd_plv_q};
            CSR_PRMD:   csr_rdata_o = {29'b0, prmd_pie_q, prmd_pplv_q};
            CSR_ECFG:   csr_rdata_o = int_word(ecfg_lie_q);
            CSR_ESTAT:  csr_rdata_o = int_word(estat_is_q) | {10'b0, estat_ecode_q, 16'b0};
            CSR_ERA:    csr_rdata_o = era_q;
            CSR_BADV:   csr_rdata_o = badv_q;
            CSR_EENTRY: csr_rdata_o = eentry_q;
            CSR_TCFG:   csr_rdata_o = {tcfg_init_q, tcfg_periodic_q, tcfg_en_q};
            CSR_TVAL:   csr_rdata_o = {tcfg_init_q, 2'b00}; // the live count sits in int_source.
            default:    csr_rdata_o = 32'b0;
        endcase
    end

    assign csr_view_o = '{
        era_pc:    era_q,
        eentry_va: eentry_q,
        ecfg_lie:  ecfg_lie_q,
        estat_is:  estat_is_q,
        crmd_ie:   crmd_ie_q
    };

    // the timer sees a TCFG write in its own cycle so that it loads at the same edge.
    assign timer_cfg_o = '{
        load:     wr_tcfg && wdata[0],
        en:       wr_tcfg ? wdata[0] : tcfg_en_q,
        periodic: wr_tcfg ? wdata[1] : tcfg_periodic_q,
        init_val: wr_tcfg ? wdata[31:2] : tcfg_init_q
    };

endmodule

//--- hdl/int_source.sv
`timescale 1ns/1ps

module int_source
    import pipeline_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,

    input  logic [7:0]       hw_int_i,
    input  timer_cfg_t       timer_cfg_i,
    input  logic             timer_clr_i,

    output logic [INT_W-1:0] int_pending_o
);

    logic [7:0]  hw_meta_q;
    logic [7:0]  hw_sync_q;
    logic [29:0] cnt_q;
    logic        running_q;
    logic        timer_pend_q;
    logic        expire;

    // the hardware lines come from other clock domains.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hw_meta_q <= '0;
            hw_sync_q <= '0;
        end
        else begin
            hw_meta_q <= hw_int_i;
            hw_sync_q <= hw_meta_q;
        end
    end

    assign expire = running_q && timer_cfg_i.en && (cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q     <= '0;
            running_q <= 1'b0;
        end
        else if (timer_cfg_i.load) begin
            cnt_q     <= timer_cfg_i.init_val;
            running_q <= 1'b1;
        end
        else if (!timer_cfg_i.en) begin
            running_q <= 1'b0; // clearing en stops the count where it is.
        end
        else if (expire) begin
            if (timer_cfg_i.periodic) begin
                cnt_q <= timer_cfg_i.init_val;
            end
            else begin
                running_q <= 1'b0;
            end
        end
        else if (running_q) begin
            cnt_q <= cnt_q - 30'd1;
        end
    end

    // a new expiry beats a clear in the same cycle.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            timer_pend_q <= 1'b0;
        end
        else begin
            timer_pend_q <= expire || (timer_pend_q && !timer_clr_i);
        end
    end

    // expire is passed straight on so ESTAT catches it one edge after zero.
    assign int_pending_o = {timer_pend_q || expire, 1'b0, hw_sync_q, 2'b00};

endmodule

//--- hdl/pipeline_pkg.sv
package pipeline_pkg;

    // exception CSR addresses.
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ECFG   = 14'h004;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_TCFG   = 14'h041;
    localparam logic [13:0] CSR_TVAL   = 14'h042;
    localparam logic [13:0] CSR_TICLR  = 14'h044;

    localparam int          EXC_SLOTS = 6;
    localparam logic [31:0] BUBBLE_PC = 32'h0000_0100; // inserted bubbles carry this pc.
    localparam int          INT_W     = 12;

    typedef enum logic [5:0] {
        EXC_INT  = 6'h00,
        EXC_ADEF = 6'h08,
        EXC_ALE  = 6'h09,
        EXC_SYS  = 6'h0b,
        EXC_BRK  = 6'h0c,
        EXC_INE  = 6'h0d,
        EXC_IPE  = 6'h0e,
        EXC_NOP  = 6'h3f
    } exc_code_e;

    // the execute stage decodes the rest, only idle stalls the pipe here.
    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_ADD  = 8'h01,
        ALU_SUB  = 8'h02,
        ALU_AND  = 8'h03,
        ALU_OR   = 8'h04,
        ALU_IDLE = 8'h70
    } alu_op_e;

    typedef struct packed {
        logic pause_id;
        logic pause_dispatch;
        logic pause_ex;
        logic pause_mem;
    } pause_req_t;

    typedef struct packed {
        logic [31:0]                     pc;
        logic [EXC_SLOTS-1:0]            is_exception;
        exc_code_e [EXC_SLOTS-1:0]       exception_cause;
        logic [31:0]                     exception_addr;
        logic                            is_ertn;
        alu_op_e                         aluop;
    } mem_trap_t;

    typedef struct packed {
        logic        csr_write_en;
        logic [13:0] csr_write_addr;
        logic [31:0] csr_write_data;
    } csr_wr_t;

    typedef struct packed {
        logic [31:0]      era_pc;
        logic [31:0]      eentry_va;
        logic [INT_W-1:0] ecfg_lie;
        logic [INT_W-1:0] estat_is;
        logic             crmd_ie;
    } csr_view_t;

    typedef struct packed {
        logic        is_exception;
        exc_code_e   exception_cause;
        logic [31:0] exception_pc;
        logic [31:0] exception_addr;
    } trap_entry_t;

    typedef struct packed {
        logic [6:0] pause; // bit 0 is pc, bit 6 is wb.
        logic       exception_flush;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] exception_new_pc;
        logic        is_interrupt;
    } ctrl_pc_t;

    // load is high in the cycle that TCFG is written with en set.
    typedef struct packed {
        logic        load;
        logic        en;
        logic        periodic;
        logic [29:0] init_val;
    } timer_cfg_t;

    function automatic logic csr_wr_hit(input csr_wr_t wr, input logic [13:0] addr);
        return wr.csr_write_en && (wr.csr_write_addr == addr);
    endfunction

    // interrupt vectors skip the reserved bit 10 of ECFG and ESTAT.
    function automatic logic [INT_W-1:0] int_field(input logic [31:0] data);
        return {data[12:11], data[9:0]};
    endfunction

    function automatic logic [31:0] int_word(input logic [INT_W-1:0] vec);
        return {19'b0, vec[11:10], 1'b0, vec[9:0]};
    endfunction

endpackage

//--- hdl/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl
    import pipeline_pkg::*;
(
    input  pause_req_t  pause_req_i,
    input  mem_trap_t   mem_i,
    input  csr_wr_t     csr_wr_i,
    input  csr_view_t   csr_view_i,

    output ctrl_t       ctrl_o,
    output ctrl_pc_t    ctrl_pc_o,
    output trap_entry_t trap_o,
    output logic        ertn_o
);

    logic [31:0]      era_cur;
    logic [31:0]      eentry_cur;
    logic [INT_W-1:0] ecfg_lie_cur;
    logic [INT_W-1:0] estat_is_cur;
    logic             crmd_ie_cur;

    logic [INT_W-1:0] int_vec;
    logic             is_interrupt;
    logic             not_bubble;
    logic             has_trap;
    exc_code_e        cause;
    logic             pause_idle;
    logic [6:0]       pause;

    // a write-back CSR write in this cycle overrides the registered copy.
    assign era_cur = csr_wr_hit(csr_wr_i, CSR_ERA) ?
                     csr_wr_i.csr_write_data : csr_view_i.era_pc;
    assign eentry_cur = csr_wr_hit(csr_wr_i, CSR_EENTRY) ?
                        csr_wr_i.csr_write_data : csr_view_i.eentry_va;
    assign ecfg_lie_cur = csr_wr_hit(csr_wr_i, CSR_ECFG) ?
                          int_field(csr_wr_i.csr_write_data) : csr_view_i.ecfg_lie;
    assign estat_is_cur = csr_wr_hit(csr_wr_i, CSR_ESTAT) ?
                          int_field(csr_wr_i.csr_write_data) : csr_view_i.estat_is;
    assign crmd_ie_cur = csr_wr_hit(csr_wr_i, CSR_CRMD) ?
                         csr_wr_i.csr_write_data[2] : csr_view_i.crmd_ie;

    assign int_vec = crmd_ie_cur ? (ecfg_lie_cur & estat_is_cur) : '0;
    assign is_interrupt = |int_vec;

    assign not_bubble = (mem_i.pc != BUBBLE_PC);
    assign has_trap = not_bubble && (|mem_i.is_exception);

    // an ertn that also carries an exception is treated as the exception.
    assign ertn_o = not_bubble && mem_i.is_ertn && !has_trap;

    // the highest numbered slot is the oldest stage and wins.
    always_comb begin
        cause = EXC_NOP;
        for (int i = 0; i < EXC_SLOTS; i++) begin
            if (mem_i.is_exception[i]) begin
                cause = mem_i.exception_cause[i];
            end
        end
    end

    assign trap_o = '{
        is_exception:    has_trap,
        exception_cause: has_trap ? cause : EXC_NOP,
        exception_pc:    mem_i.pc,
        exception_addr:  mem_i.exception_addr
    };

    assign pause_idle = (mem_i.aluop == ALU_IDLE) && !is_interrupt; // idle waits for an interrupt.

    always_comb begin
        if (pause_req_i.pause_id) begin
            pause = 7'b0000111;
        end
        else if (pause_req_i.pause_dispatch) begin
            pause = 7'b0001111;
        end
        else if (pause_req_i.pause_ex) begin
            pause = 7'b0011111;
        end
        else if (pause_req_i.pause_mem || pause_idle) begin
            pause = 7'b0111111;
        end
        else begin
            pause = 7'b0000000;
        end
    end

    assign ctrl_o = '{
        pause:           pause,
        exception_flush: has_trap || ertn_o
    };

    assign ctrl_pc_o = '{
        exception_new_pc: ertn_o ? era_cur : eentry_cur,
        is_interrupt:     is_interrupt
    };

endmodule

//--- hdl/trap_ctrl_top.sv
`timescale 1ns/1ps

module trap_ctrl_top
    import pipeline_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,

    input  pause_req_t  pause_req_i,
    input  mem_trap_t   mem_i,
    input  csr_wr_t     csr_wr_i,
    input  logic [13:0] csr_raddr_i,
    input  logic [7:0]  hw_int_i,

    output ctrl_t       ctrl_o,
    output ctrl_pc_t    ctrl_pc_o,
    output logic [31:0] csr_rdata_o
);

    csr_view_t        csr_view;
    trap_entry_t      trap_entry;
    logic             ertn;
    timer_cfg_t       timer_cfg;
    logic             timer_clr;
    logic [INT_W-1:0] int_pending;

    // the write-back write reaches both blocks, csr_file stores it and trap_ctrl forwards it.
    trap_ctrl trap_ctrl_i (
        .pause_req_i (pause_req_i),
        .mem_i       (mem_i),
        .csr_wr_i    (csr_wr_i),
        .csr_view_i  (csr_view),
        .ctrl_o      (ctrl_o),
        .ctrl_pc_o   (ctrl_pc_o),
        .trap_o      (trap_entry),
        .ertn_o      (ertn)
    );

    csr_file csr_file_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .csr_raddr_i   (csr_raddr_i),
        .csr_wr_i      (csr_wr_i),
        .trap_i        (trap_entry),
        .ertn_i        (ertn),
        .int_pending_i (int_pending),
        .csr_rdata_o   (csr_rdata_o),
        .csr_view_o    (csr_view),
        .timer_cfg_o   (timer_cfg),
        .timer_clr_o   (timer_clr)
    );

    int_source int_source_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .hw_int_i      (hw_int_i),
        .timer_cfg_i   (timer_cfg),
        .timer_clr_i   (timer_clr),
        .int_pending_o (int_pending)
    );

endmodule

//--- verification/trap_ctrl_props.sv
`timescale 1ns/1ps

module trap_ctrl_props
    import pipeline_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input mem_trap_t mem_i,
    input csr_wr_t   csr_wr_i,
    input csr_view_t csr_view_i,
    input ctrl_t     ctrl_i,
    input ctrl_pc_t  ctrl_pc_i
);

    int unsigned fail_count = 0;
    logic        crmd_fwd;

    assign crmd_fwd = csr_wr_i.csr_write_en && (csr_wr_i.csr_write_addr == CSR_CRMD);

    flush_not_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        ctrl_i.exception_flush |-> (mem_i.pc != BUBBLE_PC))
        else begin
            $error("flush raised while the memory stage holds a bubble");
            fail_count++;
        end

    // each pattern stalls a prefix of the pipe ending at the requesting stage.
    pause_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        ctrl_i.pause inside {7'b000_0000, 7'b000_0111, 7'b000_1111, 7'b001_1111, 7'b011_1111})
        else begin
            $error("pause vector %b is not a legal pattern", ctrl_i.pause);
            fail_count++;
        end

    intr_needs_ie: assert property (@(posedge clk) disable iff (!rst_n_i)
        (!csr_view_i.crmd_ie && !crmd_fwd) |-> !ctrl_pc_i.is_interrupt)
        else begin
            $error("interrupt flagged while CRMD.IE is clear");
            fail_count++;
        end

endmodule

bind trap_ctrl_top trap_ctrl_props trap_ctrl_props_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .mem_i      (mem_i),
    .csr_wr_i   (csr_wr_i),
    .csr_view_i (csr_view),
    .ctrl_i     (ctrl_o),
    .ctrl_pc_i  (ctrl_pc_o)
);

//--- verification/trap_ctrl_model.svh
`ifndef TRAP_CTRL_MODEL_SVH
`define TRAP_CTRL_MODEL_SVH

// expected CSR state, updated at every rising edge after reset.
logic [1:0]  m_plv;
logic        m_ie;
logic [1:0]  m_pplv;
logic        m_pie;
logic [11:0] m_lie;
logic [1:0]  m_swi;
logic [7:0]  m_hwi;  // set by the testbench when a line is due in ESTAT.IS.
logic        m_tmr;
logic [5:0]  m_ecode;
logic [31:0] m_era;
logic [31:0] m_badv;
logic [31:0] m_eentry;
logic [31:0] m_tcfg;

function automatic void m_reset();
    {m_plv, m_ie, m_pplv, m_pie} = '0;
    {m_lie, m_swi, m_hwi, m_tmr, m_ecode} = '0;
    {m_era, m_badv, m_eentry, m_tcfg} = '0;
endfunction

function automatic logic writes_csr(input csr_wr_t wr, input logic [13:0] addr);
    return wr.csr_write_en && wr.csr_write_addr == addr;
endfunction

// ECFG and ESTAT keep bit 10 of the word reserved.
function automatic logic [11:0] pack_int(input logic [31:0] d);
    return {d[12:11], d[9:0]};
endfunction

function automatic logic [31:0] spread_int(input logic [11:0] v);
    return {19'b0, v[11:10], 1'b0, v[9:0]};
endfunction

function automatic logic m_intr(input csr_wr_t wr);
    logic        ie;
    logic [11:0] lie;
    logic [11:0] is;
    ie = writes_csr(wr, CSR_CRMD) ? wr.csr_write_data[2] : m_ie;
    lie = writes_csr(wr, CSR_ECFG) ? pack_int(wr.csr_write_data) : m_lie;
    is = writes_csr(wr, CSR_ESTAT) ? pack_int(wr.csr_write_data) : {m_tmr, 1'b0, m_hwi, m_swi};
    return ie && |(lie & is);
endfunction

function automatic logic m_trap(input mem_trap_t m);
    return m.pc != BUBBLE_PC && |m.is_exception;
endfunction

function automatic logic m_ertn(input mem_trap_t m);
    return m.pc != BUBBLE_PC && m.is_ertn && !m_trap(m);
endfunction

function automatic exc_code_e m_cause(input mem_trap_t m);
    for (int i = EXC_SLOTS - 1; i >= 0; i--) begin
        if (m.is_exception[i]) begin
            return m.exception_cause[i];
        end
    end
    return EXC_NOP;
endfunction

function automatic logic [6:0] m_pause(input pause_req_t p, input logic idle_wait);
    if (p.pause_id) return 7'b000_0111; // pc, if and id hold.
    if (p.pause_dispatch) return 7'b000_1111;
    if (p.pause_ex) return 7'b001_1111;
    if (p.pause_mem || idle_wait) return 7'b011_1111;
    return 7'b000_0000;
endfunction

function automatic ctrl_t m_ctrl(input pause_req_t p, input mem_trap_t m, input csr_wr_t wr);
    ctrl_t c;
    c.pause = m_pause(p, m.aluop == ALU_IDLE && !m_intr(wr));
    c.exception_flush = m_trap(m) || m_ertn(m);
    return c;
endfunction

function automatic ctrl_pc_t m_pc(input mem_trap_t m, input csr_wr_t wr);
    ctrl_pc_t c;
    if (m_ertn(m)) begin
        c.exception_new_pc = writes_csr(wr, CSR_ERA) ? wr.csr_write_data : m_era;
    end
    else begin
        c.exception_new_pc = writes_csr(wr, CSR_EENTRY) ? wr.csr_write_data : m_eentry;
    end
    c.is_interrupt = m_intr(wr);
    return c;
endfunction

// the software write goes first, a trap then overrides the fields it shares.
function automatic void m_commit(input mem_trap_t m, input csr_wr_t wr);
    logic [31:0] d;
    logic [2:0]  crmd_old;
    logic [2:0]  prmd_old;
    d = wr.csr_write_data;
    crmd_old = {m_ie, m_plv};
    prmd_old = {m_pie, m_pplv};
    if (wr.csr_write_en) begin
        case (wr.csr_write_addr)
            CSR_CRMD:   {m_ie, m_plv} = d[2:0];
            CSR_PRMD:   {m_pie, m_pplv} = d[2:0];
            CSR_ECFG:   m_lie = pack_int(d);
            CSR_ESTAT:  m_swi = d[1:0];
            CSR_ERA:    m_era = d;
            CSR_BADV:   m_badv = d;
            CSR_EENTRY: m_eentry = d;
            CSR_TCFG:   m_tcfg = d;
            CSR_TICLR:  m_tmr = m_tmr && !d[0];
            default:    ;
        endcase
    end
    if (m_trap(m)) begin
        {m_pie, m_pplv} = crmd_old;
        {m_ie, m_plv} = 3'b000;
        m_era = m.pc;
        m_ecode = m_cause(m);
        if (m_cause(m) == EXC_ADEF || m_cause(m) == EXC_ALE) begin
            m_badv = m.exception_addr;
        end
    end
    else if (m_ertn(m)) begin
        {m_ie, m_plv} = prmd_old;
    end
endfunction

function automatic logic [31:0] m_read(input logic [13:0] addr);
    case (addr)
        CSR_CRMD:   return {29'b0, m_ie, m_plv};
        CSR_PRMD:   return {29'b0, m_pie, m_pplv};
        CSR_ECFG:   return spread_int(m_lie);
        CSR_ESTAT:  return spread_int({m_tmr, 1'b0, m_hwi, m_swi}) | {10'b0, m_ecode, 16'b0};
        CSR_ERA:    return m_era;
        CSR_BADV:   return m_badv;
        CSR_EENTRY: return m_eentry;
        CSR_TCFG:   return m_tcfg;
        CSR_TVAL:   return {m_tcfg[31:2], 2'b00};
        default:    return 32'b0;
    endcase
endfunction

`endif

//--- verification/trap_ctrl_tb.sv
`timescale 1ns/1ps

module trap_ctrl_tb
    import pipeline_pkg::*;
;

    logic        clk;
    logic        rst_n;
    pause_req_t  pause_req;
    mem_trap_t   mem;
    csr_wr_t     csr_wr;
    logic [13:0] raddr;
    logic [7:0]  hw_int;
    ctrl_t       ctrl;
    ctrl_pc_t    ctrl_pc;
    logic [31:0] rdata;
    logic [31:0] seed;

    exc_code_e   causes   [7]  = '{EXC_INT, EXC_ADEF, EXC_ALE, EXC_SYS, EXC_BRK, EXC_INE, EXC_IPE};
    logic [13:0] wr_addrs [7]  = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                                   CSR_EENTRY};
    logic [13:0] rd_addrs [10] = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV,
                                   CSR_EENTRY, CSR_TCFG, CSR_TVAL, 14'h3ff};

    `include "trap_ctrl_model.svh"

    trap_ctrl_top trap_ctrl_top_i (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .pause_req_i (pause_req),
        .mem_i       (mem),
        .csr_wr_i    (csr_wr),
        .csr_raddr_i (raddr),
        .hw_int_i    (hw_int),
        .ctrl_o      (ctrl),
        .ctrl_pc_o   (ctrl_pc),
        .csr_rdata_o (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    initial begin
        #100_000;
        $display("simulation ran past its time limit");
        stop_on_error();
    end

    // the bound assertions count their failures.
    always @(posedge clk) begin
        if (trap_ctrl_top_i.trap_ctrl_props_i.fail_count != 0) begin
            $display("a bound assertion on trap_ctrl_top failed");
            stop_on_error();
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t %s pause %b flush %b, expected pause %b flush %b", $time, what,
                     got.pause, got.exception_flush, exp.pause, exp.exception_flush);
            stop_on_error();
        end
    endtask

    task automatic check_pc(input ctrl_pc_t got, input ctrl_pc_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t %s new_pc %h interrupt %b, expected new_pc %h interrupt %b",
                     $time, what, got.exception_new_pc, got.is_interrupt,
                     exp.exception_new_pc, exp.is_interrupt);
            stop_on_error();
        end
    endtask

    task automatic check_csr(input logic [13:0] addr, input logic [31:0] got,
                             input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t %s csr %h read %h, expected %h", $time, what, addr, got, exp);
            stop_on_error();
        end
    endtask

    // the model takes the inputs of the ending cycle at the same edge as the DUT.
    task automatic next_cycle();
        @(posedge clk);
        m_commit(mem, csr_wr);
        #1;
    endtask

    task automatic compare_outputs(input string what);
        #2;
        check_ctrl(ctrl, m_ctrl(pause_req, mem, csr_wr), what);
        check_pc(ctrl_pc, m_pc(mem, csr_wr), what);
        check_csr(raddr, rdata, m_read(raddr), what);
    endtask

    task automatic drive_idle();
        pause_req = '0;
        mem = '0;
        mem.pc = BUBBLE_PC;
        mem.aluop = ALU_NOP;
        csr_wr = '0;
    endtask

    task automatic write_csr(input logic [13:0] addr, input logic [31:0] data);
        next_cycle();
        drive_idle();
        csr_wr = '{csr_write_en: 1'b1, csr_write_addr: addr, csr_write_data: data};
        compare_outputs("csr write");
    endtask

    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] a;
        r = next_rand();
        a = next_rand();
        drive_idle();
        if (r[1:0] == 2'b00) begin
            pause_req = pause_req_t'(r[5:2]);
        end
        mem.pc = (r[8:6] == 3'b000) ? BUBBLE_PC : {a[31:2], 2'b00}; // a bubble now and then.
        a = next_rand();
        if (r[11:9] < 3'd2) begin
            mem.is_exception = (r[17:12] == 6'b0) ? 6'b000001 : r[17:12];
            for (int i = 0; i < EXC_SLOTS; i++) begin
                mem.exception_cause[i] = causes[a[i*4 +: 4] % 7];
            end
        end
        else if (r[11:9] == 3'd2) begin
            mem.is_ertn = 1'b1;
        end
        mem.exception_addr = next_rand();
        if (r[20:18] == 3'b000) begin
            mem.aluop = ALU_IDLE;
        end
        if (r[22:21] != 2'b00) begin
            csr_wr.csr_write_en = 1'b1;
            csr_wr.csr_write_addr = wr_addrs[r[25:23] % 7];
            csr_wr.csr_write_data = next_rand();
        end
        raddr = rd_addrs[r[29:26] % 10];
    endtask

    // a hardware line passes two synchronizer flops and the IS register.
    task automatic wait_hw(input int line, input logic level);
        int edges;
        edges = 0;
        while (ctrl_pc.is_interrupt !== level && edges < 64) begin
            next_cycle();
            drive_idle();
            mem.aluop = ALU_IDLE;
            edges++;
            if (edges == 3) m_hwi[line] = level;
            compare_outputs("hardware interrupt wait");
        end
        if (ctrl_pc.is_interrupt !== level) begin
            $display("timeout while waiting for is_interrupt to become %b", level);
            stop_on_error();
        end
    endtask

    task automatic hw_interrupt_test(input int line);
        raddr = CSR_ESTAT;
        write_csr(CSR_ESTAT, 32'h0);
        write_csr(CSR_ECFG, 32'h1 << (line + 2));
        write_csr(CSR_CRMD, 32'h4);
        next_cycle();
        drive_idle();
        mem.aluop = ALU_IDLE;
        hw_int[line] = 1'b1;
        compare_outputs("idle with a rising line");
        wait_hw(line, 1'b1);
        hw_int[line] = 1'b0;
        wait_hw(line, 1'b0);
        write_csr(CSR_CRMD, 32'h0);
        write_csr(CSR_ECFG, 32'h0);
    endtask

    task automatic wait_timer(input int due, input string what);
        int edges;
        edges = 0;
        while (!rdata[12] && edges < 64) begin
            next_cycle();
            drive_idle();
            edges++;
            if (edges == due) m_tmr = 1'b1;
            compare_outputs(what);
        end
        if (!rdata[12]) begin
            $display("timeout while waiting for the timer bit in ESTAT");
            stop_on_error();
        end
    endtask

    task automatic clear_timer();
        write_csr(CSR_TICLR, 32'h1);
        next_cycle();
        drive_idle();
        compare_outputs("timer clear");
    endtask

    task automatic timer_test(input logic periodic, input int n);
        raddr = CSR_ESTAT;
        write_csr(CSR_TCFG, {n[29:0], periodic, 1'b1});
        wait_timer(n + 2, "timer expiry"); // the write edge, then init_val plus one.
        clear_timer();
        if (periodic) begin
            wait_timer(n - 1, "timer reload"); // one period of init_val plus one after expiry.
            write_csr(CSR_TCFG, 32'h0);
            clear_timer();
        end
        else begin
            repeat (2 * n + 4) begin
                next_cycle();
                drive_idle();
                compare_outputs("one-shot timer stays quiet");
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        drive_idle();
        hw_int = 8'h00;
        raddr = CSR_CRMD;
        seed = 32'h8f1d_9172;
        m_reset();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        compare_outputs("after reset");
        repeat (600) begin
            next_cycle();
            drive_random();
            compare_outputs("random cycle");
        end
        hw_interrupt_test(3);
        timer_test(1'b0, 5);
        timer_test(1'b1, 5);
        if (trap_ctrl_top_i.trap_ctrl_props_i.fail_count != 0) begin
            $display("a bound assertion on trap_ctrl_top failed");
            stop_on_error();
        end
        else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+verification
hdl/pipeline_pkg.sv
hdl/trap_ctrl.sv
hdl/csr_file.sv
hdl/int_source.sv
hdl/trap_ctrl_top.sv
verification/trap_ctrl_props.sv
verification/trap_ctrl_tb.sv
